//--- src/accel_pkg.sv
package accel_pkg;

  localparam int IO_DATA_WIDTH = 32;
  localparam int LEN_WIDTH     = 14;
  localparam int NUM_PREFIXES  = 8;

  // accelerator view register index counts words of four bytes
  localparam logic [3:0] REG_CTRL     = 4'h0;
  localparam logic [3:0] REG_LEN      = 4'h1;
  localparam logic [3:0] REG_ADDR     = 4'h2;
  localparam logic [3:0] REG_RESULT   = 4'h3;
  localparam logic [3:0] REG_PATTERN  = 4'h4;
  localparam logic [3:0] REG_PREAMBLE = 4'h5;
  localparam logic [3:0] REG_ERROR    = 4'h6;

  typedef struct packed {
    logic        sel;
    logic [10:0] unused;
  } io_ip_view_t;

  typedef struct packed {
    logic       sel;
    logic [4:0] rsvd;
    logic [3:0] idx;
    logic [1:0] lane;
  } io_acc_view_t;

  // bit 11 picks which of the two views applies
  typedef union packed {
    io_ip_view_t  ip;
    io_acc_view_t acc;
  } io_addr_t;

  typedef struct packed {
    logic [31:0] prefix;
    logic [5:0]  len;
  } ip_prefix_t;

  // prefixes in network order with the first octet in bits 31:24
  localparam ip_prefix_t BLOCKED_PREFIXES [NUM_PREFIXES] = '{
    '{32'h0A00_0000, 6'd8},
    '{32'hAC10_0000, 6'd12},
    '{32'hC0A8_0000, 6'd16},
    '{32'h6440_0000, 6'd10},
    '{32'hC612_0000, 6'd15},
    '{32'hCB00_7100, 6'd24},
    '{32'hC000_0200, 6'd24},
    '{32'h0808_0808, 6'd32}
  };

endpackage

//--- src/accel_regs.sv
`timescale 1ns/100ps

module accel_regs (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                io_en,
  input  logic                                io_wen,
  input  accel_pkg::io_addr_t                 io_addr,
  input  logic [accel_pkg::IO_DATA_WIDTH-1:0] io_wr_data,
  output logic [accel_pkg::IO_DATA_WIDTH-1:0] io_rd_data,
  output logic                                io_rd_valid,
  input  logic                                dma_busy,
  input  logic                                desc_error,
  input  logic                                match,
  input  logic [accel_pkg::LEN_WIDTH-1:0]     match_index,
  input  logic                                run_done,
  input  logic                                ip_match,
  input  logic                                ip_done,
  output logic                                desc_valid,
  output logic [31:0]                         desc_addr,
  output logic [accel_pkg::LEN_WIDTH-1:0]     desc_len,
  output logic                                stop,
  output logic                                reload,
  output logic [31:0]                         pattern,
  output logic [23:0]                         preamble,
  output logic [31:0]                         ip_addr,
  output logic                                ip_valid
);

  import accel_pkg::*;

  logic                     wr_req;
  logic                     wr_ip;
  logic                     wr_ctrl;
  logic                     start_wr;
  logic                     stop_wr;
  logic                     rd_req;
  logic                     rd_stall;
  logic                     rd_active;
  logic                     stall_sel;
  logic                     rd_ready;
  logic                     done_flag;
  logic                     match_flag;
  logic                     error_flag;
  logic [IO_DATA_WIDTH-1:0] rd_mux;

  assign wr_req   = io_en & io_wen;
  assign wr_ip    = wr_req & io_addr.ip.sel;
  assign wr_ctrl  = wr_req & ~io_addr.acc.sel & (io_addr.acc.idx == REG_CTRL);
  assign start_wr = wr_ctrl & io_wr_data[0];
  assign stop_wr  = wr_ctrl & io_wr_data[4];

  // host holds the address for the whole stall
  assign rd_req    = io_en & ~io_wen & ~rd_stall;
  assign rd_active = rd_req | rd_stall;
  assign stall_sel = io_addr.ip.sel | (io_addr.acc.idx == REG_RESULT);
  // ip_valid still high means the checker has not dropped the old done yet
  assign rd_ready  = io_addr.ip.sel ? (ip_done & ~ip_valid) : (done_flag | match_flag);

  always_comb begin
    rd_mux = '0;
    if (io_addr.ip.sel) begin
      rd_mux[0] = ip_match;
    end else begin
      case (io_addr.acc.idx)
        REG_CTRL: begin
          rd_mux[1] = dma_busy;
          rd_mux[8] = done_flag;
          rd_mux[9] = match_flag;
        end
        REG_LEN:      rd_mux[LEN_WIDTH-1:0] = desc_len;
        REG_ADDR:     rd_mux = desc_addr;
        REG_RESULT: begin
          rd_mux[16]            = match_flag;
          rd_mux[LEN_WIDTH-1:0] = match_index;
        end
        REG_PATTERN:  rd_mux = pattern;
        REG_PREAMBLE: rd_mux[23:0] = preamble;
        REG_ERROR:    rd_mux[0] = error_flag;
        default:      rd_mux = '0;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      desc_valid  <= 1'b0;
      reload      <= 1'b0;
      stop        <= 1'b0;
      ip_valid    <= 1'b0;
      io_rd_valid <= 1'b0;
      rd_stall    <= 1'b0;
      done_flag   <= 1'b0;
      match_flag  <= 1'b0;
      error_flag  <= 1'b0;
    end else begin
      desc_valid  <= start_wr;
      reload      <= start_wr;
      stop        <= stop_wr;
      ip_valid    <= wr_ip;
      io_rd_valid <= 1'b0;

      if (rd_active) begin
        if (!stall_sel || rd_ready) begin
          io_rd_valid <= 1'b1;
          rd_stall    <= 1'b0;
        end else begin
          rd_stall <= 1'b1;
        end
      end

      // a start clears the status of the previous run
      if (start_wr) begin
        done_flag  <= 1'b0;
        match_flag <= 1'b0;
        error_flag <= 1'b0;
      end else begin
        done_flag  <= done_flag | run_done | stop | desc_error;
        match_flag <= match_flag | match;
        error_flag <= error_flag | desc_error;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_ip) begin
      // host byte order to network order
      ip_addr <= {io_wr_data[7:0], io_wr_data[15:8], io_wr_data[23:16], io_wr_data[31:24]};
    end else if (wr_req) begin
      case (io_addr.acc.idx)
        REG_LEN:      desc_len <= io_wr_data[LEN_WIDTH-1:0];
        REG_ADDR:     desc_addr <= io_wr_data;
        REG_PATTERN:  pattern <= io_wr_data;
        REG_PREAMBLE: preamble <= io_wr_data[23:0];
        default: ;
      endcase
    end
    if (rd_active) begin
      io_rd_data <= rd_mux;
    end
  end

endmodule

//--- src/pmem_rd_dma.sv
`timescale 1ns/100ps

module pmem_rd_dma #(
  parameter int PMEM_ADDR_WIDTH = 8
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                desc_valid,
  input  logic [31:0]                         desc_addr,
  input  logic [accel_pkg::LEN_WIDTH-1:0]     desc_len,
  input  logic                                stop,
  output logic                                desc_error,
  output logic                                busy,
  output logic                                mem_en,
  output logic [PMEM_ADDR_WIDTH-1:0]          mem_addr,
  input  logic [accel_pkg::IO_DATA_WIDTH-1:0] mem_rd_data,
  output logic [accel_pkg::IO_DATA_WIDTH-1:0] tdata,
  output logic [3:0]                          tkeep,
  output logic                                tlast,
  output logic                                tvalid,
  input  logic                                tready
);

  import accel_pkg::*;

  localparam logic [32:0] MEM_BYTES = 33'd4 << PMEM_ADDR_WIDTH;

  logic [LEN_WIDTH-1:0] bytes_left;
  logic                 rd_pend;
  logic [3:0]           pend_keep;
  logic                 pend_last;
  logic [32:0]          desc_end;
  logic                 desc_bad;
  logic                 accept;
  logic                 issue;

  assign desc_end = {1'b0, desc_addr} + 33'(desc_len);
  assign desc_bad = (desc_len == '0) | (desc_addr[1:0] != 2'b00) |
                    (desc_end > MEM_BYTES) | busy;
  assign accept   = desc_valid & ~desc_bad;
  // one word slot, so read only when nothing is in flight and the slot drains
  assign issue    = busy & (bytes_left != '0) & ~mem_en & ~rd_pend & (~tvalid | tready);

  always_ff @(posedge clk) begin
    if (rst) begin
      desc_error <= 1'b0;
      busy       <= 1'b0;
      mem_en     <= 1'b0;
      rd_pend    <= 1'b0;
      tvalid     <= 1'b0;
      bytes_left <= '0;
    end else begin
      desc_error <= desc_valid & desc_bad;
      mem_en     <= issue;
      rd_pend    <= mem_en;
      if (stop) begin
        busy       <= 1'b0;
        mem_en     <= 1'b0;
        rd_pend    <= 1'b0;
        tvalid     <= 1'b0;
        bytes_left <= '0;
      end else begin
        if (accept) begin
          busy       <= 1'b1;
          bytes_left <= desc_len;
        end else if (issue) begin
          bytes_left <= (bytes_left <= LEN_WIDTH'(4)) ? '0 : bytes_left - LEN_WIDTH'(4);
        end
        if (rd_pend) begin
          tvalid <= 1'b1;
        end else if (tvalid && tready) begin
          tvalid <= 1'b0;
          busy   <= ~tlast;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      mem_addr <= desc_addr[PMEM_ADDR_WIDTH+1:2];
    end else if (mem_en) begin
      mem_addr <= mem_addr + 1'b1;
    end
    // keep and last follow the read through the memory latency
    if (issue) begin
      pend_last <= (bytes_left <= LEN_WIDTH'(4));
      pend_keep <= (bytes_left >= LEN_WIDTH'(4)) ? 4'hF :
                   4'hF >> (3'd4 - {1'b0, bytes_left[1:0]});
    end
    if (rd_pend) begin
      tdata <= mem_rd_data;
      tkeep <= pend_keep;
      tlast <= pend_last;
    end
  end

endmodule

//--- src/pattern_matcher.sv
`timescale 1ns/100ps

module pattern_matcher (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                reload,
  input  logic [23:0]                         preamble,
  input  logic [31:0]                         pattern,
  input  logic [accel_pkg::IO_DATA_WIDTH-1:0] tdata,
  input  logic [3:0]                          tkeep,
  input  logic                                tlast,
  input  logic                                tvalid,
  output logic                                tready,
  output logic                                match,
  output logic [accel_pkg::LEN_WIDTH-1:0]     match_index,
  output logic                                run_done
);

  import accel_pkg::*;

  logic [IO_DATA_WIDTH-1:0] word;
  logic [3:0]               keep;
  logic                     last;
  logic                     loaded;
  logic [23:0]              hist;
  logic                     found;
  logic [LEN_WIDTH-1:0]     byte_idx;
  logic [7:0]               cur;
  logic                     hit;
  logic                     word_end;
  logic                     accept;

  // back-pressure while a word is still being shifted out
  assign tready   = ~loaded & ~reload;
  assign accept   = tvalid & tready;
  assign cur      = word[7:0];
  // oldest history byte lines up with the pattern msb
  assign hit      = ({hist, cur} == pattern);
  assign word_end = (keep[3:1] == 3'b000);

  always_ff @(posedge clk) begin
    if (rst) begin
      loaded   <= 1'b0;
      keep     <= 4'b0;
      last     <= 1'b0;
      found    <= 1'b0;
      byte_idx <= '0;
      match    <= 1'b0;
      run_done <= 1'b0;
    end else begin
      match    <= 1'b0;
      run_done <= 1'b0;
      if (reload) begin
        loaded   <= 1'b0;
        found    <= 1'b0;
        byte_idx <= '0;
      end else if (accept) begin
        loaded <= 1'b1;
        keep   <= tkeep;
        last   <= tlast;
      end else if (loaded) begin
        byte_idx <= byte_idx + 1'b1;
        keep     <= keep >> 1;
        if (hit && !found) begin
          found <= 1'b1;
          match <= 1'b1;
        end
        if (word_end) begin
          loaded   <= 1'b0;
          run_done <= last;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reload) begin
      hist        <= preamble;
      match_index <= '0;
    end else if (accept) begin
      word <= tdata;
    end else if (loaded) begin
      word <= word >> 8;
      hist <= {hist[15:0], cur};
      if (hit && !found) begin
        match_index <= byte_idx;
      end
    end
  end

endmodule

//--- src/ip_prefix_check.sv
`timescale 1ns/100ps

module ip_prefix_check (
  input  logic        clk,
  input  logic        rst,
  input  logic        ip_valid,
  input  logic [31:0] ip_addr,
  output logic        ip_match,
  output logic        done
);

  import accel_pkg::*;

  localparam int SEL_W = $clog2(NUM_PREFIXES);

  logic [31:0]      addr_q;
  logic [SEL_W-1:0] entry_sel;
  ip_prefix_t       entry;
  logic [31:0]      mask;
  logic             hit;

  assign entry = BLOCKED_PREFIXES[entry_sel];
  // top len bits take part in the compare
  assign mask  = ~(32'hFFFF_FFFF >> entry.len);
  assign hit   = ((addr_q ^ entry.prefix) & mask) == 32'h0;

  always_ff @(posedge clk) begin
    if (rst) begin
      // idle checker reports a clean verdict
      done      <= 1'b1;
      ip_match  <= 1'b0;
      entry_sel <= '0;
    end else if (ip_valid) begin
      done      <= 1'b0;
      ip_match  <= 1'b0;
      entry_sel <= '0;
    end else if (!done) begin
      ip_match  <= ip_match | hit;
      entry_sel <= entry_sel + 1'b1;
      if (entry_sel == SEL_W'(NUM_PREFIXES - 1)) begin
        done <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ip_valid) begin
      addr_q <= ip_addr;
    end
  end

endmodule

//--- src/accel_top.sv
`timescale 1ns/100ps

module accel_top #(
  parameter int PMEM_ADDR_WIDTH = 8
) (
  input  logic                                clk,
  input  logic                                rst,
  input  logic                                io_en,
  input  logic                                io_wen,
  input  accel_pkg::io_addr_t                 io_addr,
  input  logic [accel_pkg::IO_DATA_WIDTH-1:0] io_wr_data,
  output logic [accel_pkg::IO_DATA_WIDTH-1:0] io_rd_data,
  output logic                                io_rd_valid,
  output logic                                mem_en,
  output logic [PMEM_ADDR_WIDTH-1:0]          mem_addr,
  input  logic [accel_pkg::IO_DATA_WIDTH-1:0] mem_rd_data
);

  import accel_pkg::*;

  logic                     dma_busy;
  logic                     desc_error;
  logic                     desc_valid;
  logic [31:0]              desc_addr;
  logic [LEN_WIDTH-1:0]     desc_len;
  logic                     stop;
  logic                     reload;
  logic [31:0]              pattern;
  logic [23:0]              preamble;
  logic [31:0]              ip_addr;
  logic                     ip_valid;
  logic                     ip_match;
  logic                     ip_done;
  logic                     match;
  logic [LEN_WIDTH-1:0]     match_index;
  logic                     run_done;
  // word stream from the DMA to the matcher
  logic [IO_DATA_WIDTH-1:0] tdata;
  logic [3:0]               tkeep;
  logic                     tlast;
  logic                     tvalid;
  logic                     tready;

  accel_regs u_regs (
    .clk         (clk),
    .rst         (rst),
    .io_en       (io_en),
    .io_wen      (io_wen),
    .io_addr     (io_addr),
    .io_wr_data  (io_wr_data),
    .io_rd_data  (io_rd_data),
    .io_rd_valid (io_rd_valid),
    .dma_busy    (dma_busy),
    .desc_error  (desc_error),
    .match       (match),
    .match_index (match_index),
    .run_done    (run_done),
    .ip_match    (ip_match),
    .ip_done     (ip_done),
    .desc_valid  (desc_valid),
    .desc_addr   (desc_addr),
    .desc_len    (desc_len),
    .stop        (stop),
    .reload      (reload),
    .pattern     (pattern),
    .preamble    (preamble),
    .ip_addr     (ip_addr),
    .ip_valid    (ip_valid)
  );

  pmem_rd_dma #(
    .PMEM_ADDR_WIDTH (PMEM_ADDR_WIDTH)
  ) u_dma (
    .clk         (clk),
    .rst         (rst),
    .desc_valid  (desc_valid),
    .desc_addr   (desc_addr),
    .desc_len    (desc_len),
    .stop        (stop),
    .desc_error  (desc_error),
    .busy        (dma_busy),
    .mem_en      (mem_en),
    .mem_addr    (mem_addr),
    .mem_rd_data (mem_rd_data),
    .tdata       (tdata),
    .tkeep       (tkeep),
    .tlast       (tlast),
    .tvalid      (tvalid),
    .tready      (tready)
  );

  pattern_matcher u_match (
    .clk         (clk),
    .rst         (rst),
    .reload      (reload),
    .preamble    (preamble),
    .pattern     (pattern),
    .tdata       (tdata),
    .tkeep       (tkeep),
    .tlast       (tlast),
    .tvalid      (tvalid),
    .tready      (tready),
    .match       (match),
    .match_index (match_index),
    .run_done    (run_done)
  );

  ip_prefix_check u_ip (
    .clk      (clk),
    .rst      (rst),
    .ip_valid (ip_valid),
    .ip_addr  (ip_addr),
    .ip_match (ip_match),
    .done     (ip_done)
  );

endmodule

//--- testbench/accel_tb_assert.sv
`timescale 1ns/100ps

module accel_tb_assert (
  input logic        clk,
  input logic        rst,
  input logic        io_en,
  input logic        io_wen,
  input logic        io_rd_valid,
  input logic        stop,
  input logic        tvalid,
  input logic        tready,
  input logic [31:0] tdata,
  input logic        dma_busy,
  input logic        mem_en
);

  int failures = 0;

  // a response always follows a read request held in the cycle before
  rd_valid_after_req: assert property (@(posedge clk) disable iff (rst)
    $rose(io_rd_valid) |-> $past(io_en && !io_wen))
    else begin
      $error("io_rd_valid rose without a read request");
      failures++;
    end

  // only a stop may drop the word before tready
  tvalid_held: assert property (@(posedge clk) disable iff (rst)
    (tvalid && !tready && !stop) |=> (tvalid && $stable(tdata)))
    else begin
      $error("tvalid or tdata changed before tready");
      failures++;
    end

  // the DMA fetches nothing while idle after reset or between runs
  mem_idle_without_run: assert property (@(posedge clk) disable iff (rst)
    !dma_busy |-> !mem_en)
    else begin
      $error("mem_en high while the DMA is idle");
      failures++;
    end

endmodule

bind accel_top accel_tb_assert u_assert (
  .clk         (clk),
  .rst         (rst),
  .io_en       (io_en),
  .io_wen      (io_wen),
  .io_rd_valid (io_rd_valid),
  .stop        (stop),
  .tvalid      (tvalid),
  .tready      (tready),
  .tdata       (tdata),
  .dma_busy    (dma_busy),
  .mem_en      (mem_en)
);

//--- testbench/accel_tb.sv
`timescale 1ns/100ps

module accel_tb;

  import accel_pkg::*;

  localparam int PMEM_ADDR_WIDTH = 8;
  localparam int MEM_WORDS       = 1 << PMEM_ADDR_WIDTH;
  localparam int MEM_BYTES       = 4 * MEM_WORDS;
  // 40 runs of up to 128 bytes at 4 cycles a byte plus register setup
  localparam int MAX_CYCLES      = 40 * (4 * 128 + 50);

  logic                       clk;
  logic                       rst;
  logic                       io_en;
  logic                       io_wen;
  io_addr_t                   io_addr;
  logic [IO_DATA_WIDTH-1:0]   io_wr_data;
  logic [IO_DATA_WIDTH-1:0]   io_rd_data;
  logic                       io_rd_valid;
  logic                       mem_en;
  logic [PMEM_ADDR_WIDTH-1:0] mem_addr;
  logic [IO_DATA_WIDTH-1:0]   mem_rd_data;

  logic [31:0] pmem [MEM_WORDS];
  integer      seed;
  int          cycles;
  int          errors;
  int          checks;
  int          test_errors;
  int          test_checks;

  accel_top #(
    .PMEM_ADDR_WIDTH (PMEM_ADDR_WIDTH)
  ) u_dut (
    .clk         (clk),
    .rst         (rst),
    .io_en       (io_en),
    .io_wen      (io_wen),
    .io_addr     (io_addr),
    .io_wr_data  (io_wr_data),
    .io_rd_data  (io_rd_data),
    .io_rd_valid (io_rd_valid),
    .mem_en      (mem_en),
    .mem_addr    (mem_addr),
    .mem_rd_data (mem_rd_data)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  // read data is ready one cycle after mem_en and held until the next request
  always @(negedge clk) begin
    if (mem_en) begin
      mem_rd_data <= pmem[mem_addr];
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Done: errors found");
      $finish;
    end
  end

  function automatic int urand(input int n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic io_addr_t acc_reg(input logic [3:0] idx);
    io_addr_t a;
    a         = '0;
    a.acc.idx = idx;
    return a;
  endfunction

  function automatic io_addr_t ip_reg(input logic [10:0] low);
    io_addr_t a;
    a.ip.sel    = 1'b1;
    a.ip.unused = low;
    return a;
  endfunction

  function automatic logic [31:0] swap_bytes(input logic [31:0] w);
    logic [31:0] s;
    for (int i = 0; i < 4; i++) begin
      s[8*i +: 8] = w[8*(3-i) +: 8];
    end
    return s;
  endfunction

  // byte j of the searched sequence where the three preamble bytes come first
  function automatic logic [7:0] stream_byte(input int addr, input logic [23:0] pre, input int j);
    int b;
    if (j < 3) begin
      return pre[8*(2-j) +: 8];
    end
    b = addr + j - 3;
    return pmem[b / 4][8*(b % 4) +: 8];
  endfunction

  // four bytes ending at payload byte k with the earliest byte in the msb
  function automatic logic [31:0] window_at(input int addr, input logic [23:0] pre, input int k);
    logic [31:0] w;
    for (int i = 0; i < 4; i++) begin
      w[8*(3-i) +: 8] = stream_byte(addr, pre, k + i);
    end
    return w;
  endfunction

  function automatic logic [31:0] expected_result(input int addr, input int len,
                                                  input logic [23:0] pre, input logic [31:0] pat);
    for (int k = 0; k < len; k++) begin
      if (window_at(addr, pre, k) == pat) begin
        return 32'h0001_0000 | k;
      end
    end
    return 32'h0;
  endfunction

  function automatic logic ip_blocked(input logic [31:0] host_word);
    logic [31:0] net;
    logic [31:0] mask;
    logic        blocked;
    net     = swap_bytes(host_word);
    blocked = 1'b0;
    for (int i = 0; i < NUM_PREFIXES; i++) begin
      mask = '0;
      for (int b = 0; b < BLOCKED_PREFIXES[i].len; b++) begin
        mask[31-b] = 1'b1;
      end
      if ((net & mask) == (BLOCKED_PREFIXES[i].prefix & mask)) begin
        blocked = 1'b1;
      end
    end
    return blocked;
  endfunction

  // host tasks start and end on a falling edge
  task automatic write_reg(input io_addr_t addr, input logic [31:0] data);
    io_en      = 1'b1;
    io_wen     = 1'b1;
    io_addr    = addr;
    io_wr_data = data;
    @(negedge clk);
    io_en  = 1'b0;
    io_wen = 1'b0;
  endtask

  task automatic read_reg(input io_addr_t addr, output logic [31:0] data);
    io_en   = 1'b1;
    io_wen  = 1'b0;
    io_addr = addr;
    do @(negedge clk); while (!io_rd_valid);
    data  = io_rd_data;
    io_en = 1'b0;
  endtask

  task automatic check_word(input string name, input logic [31:0] expected,
                            input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic check_addr_view(input string name, input io_addr_t addr,
                                 input logic [31:0] expected, input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("** Error %s at io_addr %h: expected %h, actual %h",
               name, addr, expected, actual);
    end
  endtask

  task automatic begin_test;
    test_errors = errors;
    test_checks = checks;
  endtask

  task automatic end_test(input string name);
    $display("%s: %0d checks, %0d errors", name, checks - test_checks, errors - test_errors);
  endtask

  task automatic start_run(input int addr, input int len, input logic [31:0] pat,
                           input logic [23:0] pre);
    write_reg(acc_reg(REG_LEN), len);
    write_reg(acc_reg(REG_ADDR), addr);
    write_reg(acc_reg(REG_PATTERN), pat);
    write_reg(acc_reg(REG_PREAMBLE), {8'h00, pre});
    write_reg(acc_reg(REG_CTRL), 32'h1);
  endtask

  task automatic wait_done(output logic [31:0] ctrl);
    ctrl = '0;
    while (!ctrl[8]) begin
      read_reg(acc_reg(REG_CTRL), ctrl);
    end
  endtask

  task automatic run_and_check(input string name, input int addr, input int len,
                               input logic [31:0] pat, input logic [23:0] pre);
    logic [31:0] exp;
    logic [31:0] result;
    logic [31:0] ctrl;
    exp = expected_result(addr, len, pre, pat);
    start_run(addr, len, pat, pre);
    // returns early on a match while the rest of the run drains
    read_reg(acc_reg(REG_RESULT), result);
    check_word(name, exp, result);
    wait_done(ctrl);
    check_word({name, " status"}, {22'b0, exp[16], 1'b1, 8'b0}, ctrl);
  endtask

  task automatic readback_test;
    logic [31:0] vals [4];
    logic [31:0] masks [4];
    logic [3:0]  idxs [4];
    logic [31:0] rd;
    idxs  = '{REG_LEN, REG_ADDR, REG_PATTERN, REG_PREAMBLE};
    masks = '{32'h0000_3FFF, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h00FF_FFFF};
    begin_test();
    for (int i = 0; i < 4; i++) begin
      vals[i] = $random(seed);
      write_reg(acc_reg(idxs[i]), vals[i]);
    end
    for (int i = 0; i < 4; i++) begin
      read_reg(acc_reg(idxs[i]), rd);
      check_word($sformatf("readback reg %0d", idxs[i]), vals[i] & masks[i], rd);
    end
    for (int i = 7; i < 16; i++) begin
      read_reg(acc_reg(i), rd);
      check_addr_view("unmapped read", acc_reg(i), 32'h0, rd);
    end
    end_test("register readback");
  endtask

  task automatic pattern_test;
    int          len;
    int          addr;
    logic [23:0] pre;
    logic [31:0] pat;
    begin_test();
    for (int r = 0; r < 24; r++) begin
      len  = 1 + urand(128);
      addr = 4 * urand((MEM_BYTES - len) / 4 + 1);
      pre  = $random(seed);
      // every third run searches for a random word that is mostly absent
      if (r % 3 == 2) begin
        pat = $random(seed);
      end else begin
        pat = window_at(addr, pre, urand(len));
      end
      run_and_check($sformatf("pattern run %0d", r), addr, len, pat, pre);
    end
    end_test("pattern runs");
  endtask

  task automatic preamble_test;
    int          len;
    int          addr;
    logic [23:0] pre;
    begin_test();
    for (int m = 0; m < 3; m++) begin
      len  = 4 + urand(60);
      addr = 4 * urand((MEM_BYTES - len) / 4 + 1);
      pre  = $random(seed);
      run_and_check($sformatf("preamble run %0d", m), addr, len, window_at(addr, pre, m), pre);
    end
    end_test("preamble spanning");
  endtask

  task automatic desc_error_test;
    int          addrs [3];
    int          lens [3];
    logic [31:0] rd;
    addrs = '{0, 2, MEM_BYTES - 4};
    lens  = '{0, 8, 8};
    begin_test();
    for (int i = 0; i < 3; i++) begin
      start_run(addrs[i], lens[i], $random(seed), $random(seed));
      read_reg(acc_reg(REG_RESULT), rd);
      check_word($sformatf("bad desc %0d result", i), 32'h0, rd);
      read_reg(acc_reg(REG_ERROR), rd);
      check_word($sformatf("bad desc %0d error", i), 32'h1, rd);
      read_reg(acc_reg(REG_CTRL), rd);
      check_word($sformatf("bad desc %0d ctrl", i), 32'h100, rd);
    end
    end_test("descriptor errors");
  endtask

  task automatic stop_test;
    logic [23:0] pre;
    logic [31:0] pat;
    logic [31:0] rd;
    int          t0;
    begin_test();
    pre = $random(seed);
    do pat = $random(seed); while (expected_result(0, 128, pre, pat) != 0);
    start_run(0, 128, pat, pre);
    repeat (12) @(negedge clk);
    write_reg(acc_reg(REG_CTRL), 32'h10);
    t0 = cycles;
    read_reg(acc_reg(REG_RESULT), rd);
    // the full run would keep the result read stalled for well over 100 cycles
    checks++;
    if (cycles - t0 > 4) begin
      errors++;
      $display("stop did not end the run: the result read took %0d cycles", cycles - t0);
    end
    check_word("stop result", 32'h0, rd);
    read_reg(acc_reg(REG_CTRL), rd);
    check_word("stop ctrl", 32'h100, rd);
    // let the matcher finish the word it holds
    repeat (8) @(negedge clk);
    end_test("stop");
  endtask

  task automatic ip_test;
    io_addr_t    a;
    logic [31:0] net;
    logic [31:0] host;
    logic [31:0] rd;
    begin_test();
    for (int i = 0; i < 24; i++) begin
      if (i < NUM_PREFIXES) begin
        net  = BLOCKED_PREFIXES[i].prefix ^ ($random(seed) >> BLOCKED_PREFIXES[i].len);
        host = swap_bytes(net);
      end else begin
        host = $random(seed);
      end
      a = ip_reg(urand(2048));
      write_reg(a, host);
      read_reg(a, rd);
      check_addr_view($sformatf("ip check %0d", i), a, {31'b0, ip_blocked(host)}, rd);
    end
    end_test("ip check");
  endtask

  initial begin
    seed        = 33921;
    cycles      = 0;
    errors      = 0;
    checks      = 0;
    rst         = 1'b1;
    io_en       = 1'b0;
    io_wen      = 1'b0;
    io_addr     = '0;
    io_wr_data  = '0;
    mem_rd_data = '0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      pmem[i] = $random(seed);
    end
    repeat (2) @(negedge clk);
    rst = 1'b0;

    readback_test();
    pattern_test();
    preamble_test();
    desc_error_test();
    stop_test();
    ip_test();

    $display("total: %0d checks, %0d errors, %0d assertion failures",
             checks, errors, u_dut.u_assert.failures);
    if (errors == 0 && u_dut.u_assert.failures == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

//--- files.f
src/accel_pkg.sv
src/accel_regs.sv
src/pmem_rd_dma.sv
src/pattern_matcher.sv
src/ip_prefix_check.sv
src/accel_top.sv
testbench/accel_tb_assert.sv
testbench/accel_tb.sv
